// File: compile.f
source/lsu_pkg.sv
source/mem_access_issue.sv
source/data_mem_bank.sv
source/load_data_converter.sv
source/lsu_subsystem.sv
verif/tb_clock_gen.sv
verif/tb_lsu_subsystem.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_lsu_subsystem
FILELIST := compile.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# pass or fail comes from the log, not from the exit code of the binary
run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: verif/tb_lsu_subsystem.sv
module tb_lsu_subsystem
    import lsu_pkg::*;
;

    localparam int CLK_PERIOD   = 8;
    localparam int LOAD_LATENCY = 3;
    localparam int N_FILL       = MEM_WORDS;
    // word 16, lane 10, extension 56 and fault 19 requests
    localparam int N_DIRECTED   = 101;
    localparam int N_RANDOM     = 2000;
    localparam int TOTAL_REQS   = N_FILL + N_DIRECTED + N_RANDOM;
    localparam int WATCHDOG_TIME = (TOTAL_REQS + 20) * CLK_PERIOD * 2;

    logic                   clk;
    logic                   arst_n;
    logic                   req_valid;
    logic                   req_store;
    logic [2:0]             req_funct3;
    logic [BYTE_ADDR_W-1:0] req_addr;
    logic [31:0]            req_wdata;
    logic                   load_done;
    logic [31:0]            load_data;
    logic                   access_fault;

    // reference memory updated when a request is issued
    logic [31:0] model_mem [MEM_WORDS];

    // expected loads in issue order
    logic [31:0] exp_data_q [$];
    string       exp_name_q [$];
    int          exp_edge_q [$];
    // sampling edges of requests that must fault
    int          fault_edge_q [$];

    string       cur_test;
    int          edge_cnt = 0;
    logic [31:0] lcg_state = 32'ha6d8_53c4;

    int data_errors     = 0;
    int latency_errors  = 0;
    int fault_errors    = 0;
    int protocol_errors = 0;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (4)
    ) i_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    lsu_subsystem i_lsu_subsystem (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_store    (req_store),
        .req_funct3   (req_funct3),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .load_done    (load_done),
        .load_data    (load_data),
        .access_fault (access_fault)
    );

    // rising edge counter
    // a request driven after edge k is sampled at edge k+1
    always @(posedge clk)
    begin
        edge_cnt <= edge_cnt + 1;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // every byte carries the word index scrambled by a constant
    function automatic logic [31:0] fill_pattern(input int idx);
        logic [31:0] v;
        v = idx;
        return (v * 32'h0101_0101) ^ 32'h5ac3_0f96;
    endfunction

    // halfwords need an even offset and words a zero one
    // stores exist only as SB, SH and SW
    function automatic logic predict_fault(input logic store, input logic [2:0] f3,
                                           input logic [1:0] off);
        logic legal_store;
        logic aligned;
        legal_store = (f3 == F3_B) || (f3 == F3_H) || (f3 == F3_W);
        case (f3[1:0])
            2'b01:   aligned = !off[0];
            2'b10:   aligned = (off == 2'b00);
            default: aligned = 1'b1;
        endcase
        return !aligned || (store && !legal_store);
    endfunction

    // expected load result from the model word
    function automatic logic [31:0] expected_load(input logic [31:0] word,
                                                  input logic [1:0] off,
                                                  input logic [2:0] f3);
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] result;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (f3)
            F3_B:    result = {{24{b[7]}}, b};
            F3_H:    result = {{16{h[15]}}, h};
            F3_BU:   result = {24'd0, b};
            F3_HU:   result = {16'd0, h};
            // LW and the codes without a format
            default: result = word;
        endcase
        return result;
    endfunction

    // store into the model by access size
    task automatic store_to_model(input logic [2:0] f3, input logic [WORD_ADDR_W-1:0] widx,
                                  input logic [1:0] off, input logic [31:0] wdata);
        case (f3[1:0])
            2'b00:   model_mem[widx][8*off +: 8] = wdata[7:0];
            2'b01:   model_mem[widx][8*off +: 16] = wdata[15:0];
            default: model_mem[widx] = wdata;
        endcase
    endtask

    // drives one request for one cycle and records what must come back
    task automatic issue_request(input logic store, input logic [2:0] f3,
                                 input logic [WORD_ADDR_W-1:0] widx, input logic [1:0] off,
                                 input logic [31:0] wdata);
        int   sample_edge;
        logic fault;
        sample_edge = edge_cnt + 1;
        fault       = predict_fault(store, f3, off);
        req_valid   = 1'b1;
        req_store   = store;
        req_funct3  = f3;
        req_addr    = {widx, off};
        req_wdata   = wdata;
        if (fault)
        begin
            fault_edge_q.push_back(sample_edge);
        end
        else if (store)
        begin
            store_to_model(f3, widx, off, wdata);
        end
        else
        begin
            exp_data_q.push_back(expected_load(model_mem[widx], off, f3));
            exp_name_q.push_back(cur_test);
            exp_edge_q.push_back(sample_edge);
        end
        @(posedge clk);
        #1 req_valid = 1'b0;
    endtask

    task automatic prefill_memory();
        cur_test = "prefill";
        for (int i = 0; i < N_FILL; i++)
        begin
            issue_request(1'b1, F3_W, i[WORD_ADDR_W-1:0], 2'b00, fill_pattern(i));
        end
    endtask

    task automatic run_word_test();
        logic [WORD_ADDR_W-1:0] widx;
        cur_test = "word_store_load";
        for (int i = 0; i < 8; i++)
        begin
            widx = WORD_ADDR_W'(3 * i + 5);
            issue_request(1'b1, F3_W, widx, 2'b00, next_rand());
        end
        for (int i = 0; i < 8; i++)
        begin
            widx = WORD_ADDR_W'(3 * i + 5);
            issue_request(1'b0, F3_W, widx, 2'b00, 32'd0);
        end
    endtask

    // byte and halfword stores into one prefilled word
    task automatic run_lane_test();
        cur_test = "sub_word_store";
        issue_request(1'b1, F3_B, 8'd20, 2'd1, 32'h1234_56a7);
        issue_request(1'b0, F3_W, 8'd20, 2'd0, 32'd0);
        issue_request(1'b1, F3_H, 8'd20, 2'd2, 32'hffff_c3e1);
        issue_request(1'b0, F3_W, 8'd20, 2'd0, 32'd0);
        issue_request(1'b1, F3_B, 8'd20, 2'd0, 32'h0000_0011);
        issue_request(1'b1, F3_B, 8'd20, 2'd3, 32'h0000_00ee);
        issue_request(1'b0, F3_W, 8'd20, 2'd0, 32'd0);
        issue_request(1'b1, F3_H, 8'd20, 2'd0, 32'h0000_9b2d);
        issue_request(1'b0, F3_W, 8'd20, 2'd0, 32'd0);
        issue_request(1'b0, F3_HU, 8'd20, 2'd2, 32'd0);
    endtask

    task automatic run_extension_test();
        logic [31:0] ext_words [4];
        logic [WORD_ADDR_W-1:0] widx;
        ext_words[0] = 32'h80ff_7f81;
        ext_words[1] = 32'hfedc_ba98;
        ext_words[2] = 32'h7f80_01ff;
        ext_words[3] = 32'hc0de_8001;
        cur_test = "sign_zero_ext";
        for (int w = 0; w < 4; w++)
        begin
            widx = WORD_ADDR_W'(48 + w);
            issue_request(1'b1, F3_W, widx, 2'd0, ext_words[w]);
            for (int o = 0; o < 4; o++)
            begin
                issue_request(1'b0, F3_B, widx, o[1:0], 32'd0);
                issue_request(1'b0, F3_BU, widx, o[1:0], 32'd0);
            end
            // halfwords only at the two even offsets
            for (int o = 0; o < 4; o += 2)
            begin
                issue_request(1'b0, F3_H, widx, o[1:0], 32'd0);
                issue_request(1'b0, F3_HU, widx, o[1:0], 32'd0);
            end
            issue_request(1'b0, F3_W, widx, 2'd0, 32'd0);
        end
    endtask

    // misaligned and undefined accesses to word 40
    task automatic run_fault_test();
        cur_test = "access_fault";
        issue_request(1'b0, F3_H, 8'd40, 2'd1, 32'd0);
        issue_request(1'b0, F3_H, 8'd40, 2'd3, 32'd0);
        issue_request(1'b0, F3_HU, 8'd40, 2'd1, 32'd0);
        issue_request(1'b1, F3_H, 8'd40, 2'd1, 32'hdead_beef);
        issue_request(1'b1, F3_H, 8'd40, 2'd3, 32'hdead_beef);
        for (int o = 1; o < 4; o++)
        begin
            issue_request(1'b0, F3_W, 8'd40, o[1:0], 32'd0);
            issue_request(1'b1, F3_W, 8'd40, o[1:0], 32'hdead_beef);
        end
        // store codes with no store format
        for (int f = 3; f < 8; f++)
        begin
            issue_request(1'b1, f[2:0], 8'd40, 2'd0, 32'hdead_beef);
        end
        // reads that show word 40 still holds its fill value
        issue_request(1'b0, F3_W, 8'd40, 2'd0, 32'd0);
        issue_request(1'b0, F3_H, 8'd40, 2'd2, 32'd0);
        issue_request(1'b0, F3_B, 8'd40, 2'd1, 32'd0);
    endtask

    // back to back mix of any funct3 at any offset
    task automatic run_random_test();
        logic [31:0] rnd;
        cur_test = "random_mix";
        for (int i = 0; i < N_RANDOM; i++)
        begin
            rnd = next_rand();
            issue_request(rnd[31], rnd[30:28], rnd[27:20], rnd[19:18], next_rand());
        end
    endtask

    // compares at the falling edge where the outputs are stable
    always @(negedge clk)
    begin
        if (arst_n)
        begin
            if (load_done)
            begin
                if (exp_data_q.size() == 0)
                begin
                    $display("load_done at edge %0d with no load outstanding", edge_cnt);
                    protocol_errors++;
                end
                else
                begin
                    if (load_data !== exp_data_q[0])
                    begin
                        $display("Mismatch in %s: expected %08h, actual %08h",
                                 exp_name_q[0], exp_data_q[0], load_data);
                        data_errors++;
                    end
                    if (edge_cnt - exp_edge_q[0] + 1 != LOAD_LATENCY)
                    begin
                        $display("wrong latency for %s: sampled at edge %0d, done at edge %0d",
                                 exp_name_q[0], exp_edge_q[0], edge_cnt);
                        latency_errors++;
                    end
                    void'(exp_data_q.pop_front());
                    void'(exp_name_q.pop_front());
                    void'(exp_edge_q.pop_front());
                end
            end
            // fault pulse expected right after the sampling edge
            if ((fault_edge_q.size() != 0) && (fault_edge_q[0] <= edge_cnt))
            begin
                if (!access_fault)
                begin
                    $display("access_fault missing for the request sampled at edge %0d",
                             fault_edge_q[0]);
                    fault_errors++;
                end
                void'(fault_edge_q.pop_front());
            end
            else if (access_fault)
            begin
                $display("access_fault at edge %0d for a request that should pass", edge_cnt);
                fault_errors++;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("Timeout: run did not finish, %0d loads still outstanding", exp_data_q.size());
        $display("Something failed");
        $finish;
    end

    initial
    begin
        req_valid  = 1'b0;
        req_store  = 1'b0;
        req_funct3 = 3'b000;
        req_addr   = '0;
        req_wdata  = 32'd0;
        cur_test   = "reset";
        wait (arst_n);
        @(posedge clk);
        #1;
        prefill_memory();
        run_word_test();
        run_lane_test();
        run_extension_test();
        run_fault_test();
        run_random_test();
        // wait until every expected load and fault has been seen
        while ((exp_data_q.size() != 0) || (fault_edge_q.size() != 0))
        begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Errors: data %0d, latency %0d, fault %0d, protocol %0d",
                 data_errors, latency_errors, fault_errors, protocol_errors);
        if (data_errors + latency_errors + fault_errors + protocol_errors == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verif/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic arst_n
);

    // free running clock, first rising edge at half a period
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held low for a few edges, released just after an edge
    initial
    begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

// File: source/lsu_subsystem.sv
module lsu_subsystem
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    // load/store request
    input  logic                   req_valid,
    input  logic                   req_store,
    input  logic [2:0]             req_funct3,
    input  logic [BYTE_ADDR_W-1:0] req_addr,
    input  logic [31:0]            req_wdata,
    // load result, three edges after the request
    output logic                   load_done,
    output logic [31:0]            load_data,
    // dropped request
    output logic                   access_fault
);

    // issue stage to memory bank
    logic                   mem_en;
    logic                   mem_we;
    logic [3:0]             mem_be;
    logic [WORD_ADDR_W-1:0] mem_word_addr;
    logic [31:0]            mem_wdata;
    logic [2:0]             mem_funct3;
    logic [1:0]             mem_offset;

    // memory bank to converter
    logic                   rd_valid;
    logic [31:0]            rd_word;
    logic [2:0]             rd_funct3;
    logic [1:0]             rd_offset;

    // alignment check, byte enables, store lanes
    mem_access_issue i_mem_access_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req_store     (req_store),
        .req_funct3    (req_funct3),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_be        (mem_be),
        .mem_word_addr (mem_word_addr),
        .mem_wdata     (mem_wdata),
        .mem_funct3    (mem_funct3),
        .mem_offset    (mem_offset),
        .access_fault  (access_fault)
    );

    // data memory
    data_mem_bank i_data_mem_bank (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_en        (mem_en),
        .mem_we        (mem_we),
        .mem_be        (mem_be),
        .mem_word_addr (mem_word_addr),
        .mem_wdata     (mem_wdata),
        .mem_funct3    (mem_funct3),
        .mem_offset    (mem_offset),
        .rd_valid      (rd_valid),
        .rd_word       (rd_word),
        .rd_funct3     (rd_funct3),
        .rd_offset     (rd_offset)
    );

    // lane select and sign/zero extension
    load_data_converter i_load_data_converter (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_valid  (rd_valid),
        .rd_word   (rd_word),
        .rd_funct3 (rd_funct3),
        .rd_offset (rd_offset),
        .load_done (load_done),
        .load_data (load_data)
    );

endmodule

// File: source/load_data_converter.sv
module load_data_converter
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    // read word and its tags from the memory bank
    input  logic        rd_valid,
    input  logic [31:0] rd_word,
    input  logic [2:0]  rd_funct3,
    input  logic [1:0]  rd_offset,
    // formatted load result
    output logic        load_done,
    output logic [31:0] load_data
);

    mem_word_u   word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic [31:0] ext_data;

    assign word = rd_word;

    // byte lane picked by the full offset
    assign sel_byte = word.bytes[rd_offset];

    // halfword lane picked by offset bit 1
    // bit 0 is always clear here, the issue stage faults odd halfwords
    assign sel_half = word.halves[rd_offset[1]];

    // extension by funct3
    always_comb
    begin
        case (rd_funct3)
            // LB
            F3_B:
            begin
                ext_data = {{24{sel_byte[7]}}, sel_byte};
            end
            // LH
            F3_H:
            begin
                ext_data = {{16{sel_half[15]}}, sel_half};
            end
            // LW
            F3_W:
            begin
                ext_data = word;
            end
            // LBU
            F3_BU:
            begin
                ext_data = {24'd0, sel_byte};
            end
            // LHU
            F3_HU:
            begin
                ext_data = {16'd0, sel_half};
            end
            // undefined formats return the raw word
            default:
            begin
                ext_data = word;
            end
        endcase
    end

    // result strobe
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            load_done <= 1'b0;
        end
        else
        begin
            load_done <= rd_valid;
        end
    end

    // result data, only meaningful with load_done
    always_ff @(posedge clk)
    begin
        if (rd_valid)
        begin
            load_data <= ext_data;
        end
    end

    // misaligned halfwords must have been stopped two stages earlier
    a_half_aligned: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rd_valid && ((rd_funct3 == F3_H) || (rd_funct3 == F3_HU))) |-> !rd_offset[0]
    );

endmodule

// File: source/data_mem_bank.sv
module data_mem_bank
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    // command from the issue stage
    input  logic                   mem_en,
    input  logic                   mem_we,
    input  logic [3:0]             mem_be,
    input  logic [WORD_ADDR_W-1:0] mem_word_addr,
    input  logic [31:0]            mem_wdata,
    input  logic [2:0]             mem_funct3,
    input  logic [1:0]             mem_offset,
    // registered read result with its tags
    output logic                   rd_valid,
    output logic [31:0]            rd_word,
    output logic [2:0]             rd_funct3,
    output logic [1:0]             rd_offset
);

    // single-port word array, contents undefined after reset
    logic [31:0] mem_array [MEM_WORDS];

    // write only the enabled byte lanes
    // read returns the old word one edge later
    always_ff @(posedge clk)
    begin
        if (mem_en)
        begin
            if (mem_we)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (mem_be[i])
                    begin
                        mem_array[mem_word_addr][8*i +: 8] <= mem_wdata[8*i +: 8];
                    end
                end
            end
            else
            begin
                rd_word   <= mem_array[mem_word_addr];
                rd_funct3 <= mem_funct3;
                rd_offset <= mem_offset;
            end
        end
    end

    // one rd_valid per read command
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_valid <= 1'b0;
        end
        else
        begin
            rd_valid <= mem_en && !mem_we;
        end
    end

    // the issue stage must enable a lane for every write
    a_write_has_be: assert property (
        @(posedge clk) disable iff (!arst_n)
        (mem_en && mem_we) |-> (mem_be != 4'b0000)
    );

endmodule

// File: source/mem_access_issue.sv
module mem_access_issue
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    // request strobe, one request per high cycle
    input  logic                   req_valid,
    input  logic                   req_store,
    input  logic [2:0]             req_funct3,
    input  logic [BYTE_ADDR_W-1:0] req_addr,
    input  logic [31:0]            req_wdata,
    // memory command
    output logic                   mem_en,
    output logic                   mem_we,
    output logic [3:0]             mem_be,
    output logic [WORD_ADDR_W-1:0] mem_word_addr,
    output logic [31:0]            mem_wdata,
    // tags carried along with a read
    output logic [2:0]             mem_funct3,
    output logic [1:0]             mem_offset,
    // rejected request pulse
    output logic                   access_fault
);

    logic [1:0] size;
    logic [1:0] offset;
    logic       misaligned;
    logic       bad_store;
    logic       fault;
    logic [3:0] be;
    mem_word_u  lane_data;

    // access size comes straight from funct3[1:0]
    assign size   = req_funct3[1:0];
    assign offset = req_addr[1:0];

    // halfwords need an even offset, words a zero one
    // bytes and size 11 have no alignment rule
    assign misaligned = ((size == F3_H[1:0]) && offset[0])
                     || ((size == F3_W[1:0]) && (offset != 2'b00));

    // stores only exist as SB, SH, SW
    assign bad_store = req_store && (req_funct3[2] || (size == 2'b11));

    assign fault = misaligned || bad_store;

    // store data lanes and byte enables
    always_comb
    begin
        lane_data = req_wdata;
        be        = 4'b1111;
        case (size)
            F3_B[1:0]:
            begin
                // same byte in every lane, enable only the addressed one
                for (int i = 0; i < 4; i++)
                begin
                    lane_data.bytes[i] = req_wdata[7:0];
                end
                be = 4'b0001 << offset;
            end
            F3_H[1:0]:
            begin
                // low byte to even lanes, high byte to odd lanes
                for (int i = 0; i < 4; i++)
                begin
                    lane_data.bytes[i] = i[0] ? req_wdata[15:8] : req_wdata[7:0];
                end
                be = offset[1] ? 4'b1100 : 4'b0011;
            end
            default:
            begin
                // word (and loads of size 11) use the data as is
                lane_data = req_wdata;
                be        = 4'b1111;
            end
        endcase
    end

    // control: either a memory command or a fault, never both
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mem_en       <= 1'b0;
            mem_we       <= 1'b0;
            access_fault <= 1'b0;
        end
        else
        begin
            mem_en       <= req_valid && !fault;
            mem_we       <= req_valid && !fault && req_store;
            access_fault <= req_valid && fault;
        end
    end

    // command payload, qualified by mem_en downstream
    always_ff @(posedge clk)
    begin
        mem_be        <= be;
        mem_word_addr <= req_addr[BYTE_ADDR_W-1:2];
        mem_wdata     <= lane_data;
        mem_funct3    <= req_funct3;
        mem_offset    <= offset;
    end

    // a request leaves either as a command or as a fault
    a_cmd_xor_fault: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(mem_en && access_fault)
    );

endmodule

// File: source/lsu_pkg.sv
package lsu_pkg;

    // data memory geometry
    // word index selects one 32-bit word of the bank
    localparam int WORD_ADDR_W = 8;

    // byte address adds the two offset bits below the word index
    localparam int BYTE_ADDR_W = WORD_ADDR_W + 2;

    // one word per index value
    localparam int MEM_WORDS = 1 << WORD_ADDR_W;

    // funct3 codes of the RV32I loads and stores
    // the two low bits give the access size, bit 2 marks an unsigned load

    // byte, sign-extended on load
    localparam logic [2:0] F3_B = 3'b000;

    // halfword, sign-extended on load
    localparam logic [2:0] F3_H = 3'b001;

    // full word
    localparam logic [2:0] F3_W = 3'b010;

    // byte, zero-extended
    localparam logic [2:0] F3_BU = 3'b100;

    // halfword, zero-extended
    localparam logic [2:0] F3_HU = 3'b101;

    // 011, 110 and 111 have no load format and pass the word through

    // one memory word, read either as bytes or as halfwords
    // lane 0 sits at the lowest byte address (little endian)
    typedef union packed {
        // byte lanes, bytes[0] = bits 7:0
        logic [3:0][7:0] bytes;
        // halfword lanes, halves[0] = bits 15:0
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage
